// File: rsa_accel.f
src/rsa_pkg.sv
src/mont_mult.sv
src/mont_ladder.sv
src/rsa_control.sv
src/rsa_result.sv
src/rsa_accel.sv
sim/rsa_accel_assertions.sv
sim/rsa_accel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rsa_accel_tb -f rsa_accel.f -o rsa_accel_sim &&
  ./obj_dir/rsa_accel_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
  echo "rsa_accel simulation passed" ||
  { echo "rsa_accel simulation failed"; exit 1; }

// File: sim/rsa_accel_tb.sv
module rsa_accel_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rsa_pkg::*;

  localparam logic [31:0] SEED = 32'd83;
  localparam int NUM_TESTS      = 20;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 2600;
  // Memory latency of 1 to 8 cycles
  localparam int LAT_BITS       = 3;
  localparam int REQS_PER_JOB   = 6;
  localparam int HOLD_CYCLES    = 6;
  localparam logic [WORD_W-1:0] IDLE_WORD = WORD_W'(1) << STATUS_IDLE;
  localparam logic [WORD_W-1:0] DONE_WORD = WORD_W'(1) << STATUS_DONE;

  logic              clk = 1'b0;
  logic              resetn;
  logic [WORD_W-1:0] command, addr_m, addr_e, addr_x, addr_r, addr_r2, addr_out;
  logic [LEN_W-1:0]  exp_len;
  logic [WORD_W-1:0] rx_data;
  logic              mem_done, mem_error;
  logic [WORD_W-1:0] status, rx_address, tx_address, tx_data;
  logic              rx_start, tx_start;

  // Operands live in mem, results land in out_mem
  logic [WORD_W-1:0] mem [0:255];
  logic [WORD_W-1:0] out_mem [0:255];
  int                lat_tab [0:REQS_PER_JOB-1];
  logic [31:0]       lfsr = SEED;
  logic              mem_busy, mem_write;
  logic [WORD_W-1:0] mem_addr;
  int                mem_wait, req_cnt;
  logic [WORD_W-1:0] exp_data, exp_addr;
  int                wr_count = 0;
  int                result_errors = 0;
  int                check_errors = 0;
  int                cycle_count = 0;

  rsa_accel UUT (
    .clk(clk), .resetn(resetn), .command(command),
    .addr_m(addr_m), .addr_e(addr_e), .addr_x(addr_x), .addr_r(addr_r),
    .addr_r2(addr_r2), .addr_out(addr_out), .exp_len(exp_len),
    .rx_data(rx_data), .mem_done(mem_done), .mem_error(mem_error),
    .status(status), .rx_start(rx_start), .rx_address(rx_address),
    .tx_start(tx_start), .tx_address(tx_address), .tx_data(tx_data)
  );

  always #4 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Square and multiply over the low len bits of e
  function automatic logic [31:0] mod_pow(input logic [31:0] x, input logic [31:0] e,
                                          input logic [31:0] m, input int len);
    logic [63:0] acc;
    logic [63:0] sq;
    acc = 64'd1 % {32'h0, m};
    sq  = {32'h0, x} % {32'h0, m};
    for (int i = 0; i < len; i++) begin
      if (e[i]) begin
        acc = (acc * sq) % {32'h0, m};
      end
      sq = (sq * sq) % {32'h0, m};
    end
    return acc[31:0];
  endfunction

  // Operands are read in the order m, e, x, r_mod, r2_mod
  function automatic logic [WORD_W-1:0] expected_read_addr(input int idx);
    case (idx)
      0:       return addr_m;
      1:       return addr_e;
      2:       return addr_x;
      3:       return addr_r;
      default: return addr_r2;
    endcase
  endfunction

  task automatic run_job(input int t);
    logic [31:0] m, e, x, r, r2, draw;
    logic [63:0] wide;
    int          len, base, writes_before;
    draw_bits(31, m);
    m[0] = 1'b1;
    if (m < 3) begin
      m = 32'd3;
    end
    draw_bits(32, x);
    x = x % m;
    draw_bits(32, e);
    e = e % m;
    draw_bits(6, draw);
    len = draw % 33;
    // Empty exponent first, then one whose used bits are all zero
    if (t == 0) begin
      len = 0;
    end else if (t == 1) begin
      len = (len == 0) ? 12 : len;
      e   = (e >> len) << len;
    end
    wide = 64'h1_0000_0000 % {32'h0, m};
    r    = wide[31:0];
    wide = ({32'h0, r} * {32'h0, r}) % {32'h0, m};
    r2   = wide[31:0];
    base = 8 * t;
    mem[base]     = m;
    mem[base + 1] = e;
    mem[base + 2] = x;
    mem[base + 3] = r;
    mem[base + 4] = r2;
    for (int i = 0; i < REQS_PER_JOB; i++) begin
      draw_bits(LAT_BITS, draw);
      lat_tab[i] = draw;
    end
    exp_data      = mod_pow(x, e, m, len);
    exp_addr      = base + 5;
    writes_before = wr_count;
    addr_m    = base;
    addr_e    = base + 1;
    addr_x    = base + 2;
    addr_r    = base + 3;
    addr_r2   = base + 4;
    addr_out  = base + 5;
    exp_len   = LEN_W'(len);
    mem_error = t[0];
    command   = CMD_COMPUTE;
    @(negedge clk);
    while (!status[STATUS_DONE]) begin
      assert (status[STATUS_ERROR] == mem_error) else begin
        check_errors++;
        $display("Error: status error bit = %h, expected %h", status[STATUS_ERROR],
                 mem_error);
      end
      @(negedge clk);
    end
    assert (wr_count == writes_before + 1) else begin
      check_errors++;
      $display("Job %0d wrote %0d results instead of one", t, wr_count - writes_before);
    end
    assert (out_mem[exp_addr[7:0]] === exp_data) else begin
      check_errors++;
      $display("Error: out_mem[%h] = %h, expected %h", exp_addr, out_mem[exp_addr[7:0]],
               exp_data);
    end
    mem_error = 1'b0;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      assert (status == DONE_WORD) else begin
        check_errors++;
        $display("Error: status = %h, expected %h", status, DONE_WORD);
      end
      assert (!rx_start) else begin
        check_errors++;
        $display("A new read started while the finished job still held the command");
      end
    end
    command = CMD_IDLE;
    @(negedge clk);
    assert (status == IDLE_WORD) else begin
      check_errors++;
      $display("Error: status = %h, expected %h", status, IDLE_WORD);
    end
  endtask

  initial begin
    resetn    = 1'b0;
    command   = CMD_IDLE;
    addr_m    = '0;
    addr_e    = '0;
    addr_x    = '0;
    addr_r    = '0;
    addr_r2   = '0;
    addr_out  = '0;
    exp_len   = '0;
    mem_error = 1'b0;
    repeat (3) @(negedge clk);
    assert (status == IDLE_WORD) else begin
      check_errors++;
      $display("Error: status = %h after reset, expected %h", status, IDLE_WORD);
    end
    resetn = 1'b1;
    repeat (4) begin
      @(negedge clk);
      assert (!rx_start && !tx_start) else begin
        check_errors++;
        $display("A memory request started with no command given");
      end
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_job(t);
    end
    $display("Ran %0d jobs: %0d result errors, %0d check errors, %0d assertion failures",
             NUM_TESTS, result_errors, check_errors, UUT.u_checks.assert_failures);
    if (result_errors == 0 && check_errors == 0 && UUT.u_checks.assert_failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Memory model, one request at a time
  initial begin
    mem_done  = 1'b0;
    rx_data   = '0;
    mem_busy  = 1'b0;
    mem_write = 1'b0;
    mem_addr  = '0;
    mem_wait  = 0;
    req_cnt   = 0;
    forever begin
      @(negedge clk);
      mem_done = 1'b0;
      if (!resetn) begin
        mem_busy = 1'b0;
      end else if (mem_busy) begin
        if (mem_wait == 0) begin
          mem_busy = 1'b0;
          mem_done = 1'b1;
          if (mem_write) begin
            out_mem[mem_addr[7:0]] = tx_data;
          end else begin
            rx_data = mem[mem_addr[7:0]];
          end
        end else begin
          mem_wait--;
        end
      end else if (rx_start || tx_start) begin
        if (rx_start) begin
          assert (rx_address == expected_read_addr(req_cnt % REQS_PER_JOB)) else begin
            check_errors++;
            $display("Error: rx_address = %h, expected %h", rx_address,
                     expected_read_addr(req_cnt % REQS_PER_JOB));
          end
        end
        mem_busy  = 1'b1;
        mem_write = tx_start;
        mem_addr  = tx_start ? tx_address : rx_address;
        mem_wait  = lat_tab[req_cnt % REQS_PER_JOB];
        req_cnt++;
      end
    end
  end

  // Result word checked as its write starts
  always @(negedge clk) begin
    if (resetn && tx_start) begin
      wr_count++;
      assert (tx_data == exp_data) else begin
        result_errors++;
        $display("Error: tx_data = %h, expected %h", tx_data, exp_data);
      end
      assert (tx_address == exp_addr) else begin
        result_errors++;
        $display("Error: tx_address = %h, expected %h", tx_address, exp_addr);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: the jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

// File: sim/rsa_accel_assertions.sv
module rsa_accel_assertions (
  input logic                       clk,
  input logic                       resetn,
  input logic                       rx_start,
  input logic                       tx_start,
  input logic                       mem_done,
  input logic                       mult_start,
  input logic                       mult_done,
  input logic [rsa_pkg::WORD_W-1:0] status
);
  timeunit 1ns;
  timeprecision 1ps;
  import rsa_pkg::*;

  int   assert_failures = 0;
  logic req_open;

  // Memory request in flight
  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_open <= 1'b0;
    end else if (rx_start || tx_start) begin
      req_open <= 1'b1;
    end else if (mem_done) begin
      req_open <= 1'b0;
    end
  end

  a_start_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(rx_start && tx_start))
    else begin
      assert_failures++;
      $error("rx_start and tx_start high in the same cycle");
    end

  a_one_request: assert property (@(posedge clk) disable iff (!resetn)
    (rx_start || tx_start) |-> !req_open)
    else begin
      assert_failures++;
      $error("new memory request before mem_done of the previous one");
    end

  a_done_owned: assert property (@(posedge clk) disable iff (!resetn)
    mem_done |-> req_open)
    else begin
      assert_failures++;
      $error("mem_done with no memory request outstanding");
    end

  // Done bit comes up right after the write completes
  a_done_after_write: assert property (@(posedge clk) disable iff (!resetn)
    $rose(status[STATUS_DONE]) |-> $past(mem_done))
    else begin
      assert_failures++;
      $error("status done rose without mem_done in the cycle before");
    end

  // Fixed multiplier latency
  a_mult_latency: assert property (@(posedge clk) disable iff (!resetn)
    $past(mult_start, MULT_LATENCY) |-> mult_done)
    else begin
      assert_failures++;
      $error("multiplier done missing after its fixed latency");
    end

endmodule

bind rsa_accel rsa_accel_assertions u_checks (
  .clk(clk), .resetn(resetn), .rx_start(rx_start), .tx_start(tx_start),
  .mem_done(mem_done), .mult_start(mult_start), .mult_done(mult_done),
  .status(status)
);

// File: src/rsa_accel.sv
module rsa_accel (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [rsa_pkg::WORD_W-1:0] command,
  input  logic [rsa_pkg::WORD_W-1:0] addr_m,
  input  logic [rsa_pkg::WORD_W-1:0] addr_e,
  input  logic [rsa_pkg::WORD_W-1:0] addr_x,
  input  logic [rsa_pkg::WORD_W-1:0] addr_r,
  input  logic [rsa_pkg::WORD_W-1:0] addr_r2,
  input  logic [rsa_pkg::WORD_W-1:0] addr_out,
  input  logic [rsa_pkg::LEN_W-1:0]  exp_len,
  input  logic [rsa_pkg::WORD_W-1:0] rx_data,
  input  logic                       mem_done,
  input  logic                       mem_error,
  output logic [rsa_pkg::WORD_W-1:0] status,
  output logic                       rx_start,
  output logic [rsa_pkg::WORD_W-1:0] rx_address,
  output logic                       tx_start,
  output logic [rsa_pkg::WORD_W-1:0] tx_address,
  output logic [rsa_pkg::WORD_W-1:0] tx_data
);
  import rsa_pkg::*;

  logic              ladder_start;
  logic              ladder_done;
  logic              wb_done;
  logic [WORD_W-1:0] op_m;
  logic [WORD_W-1:0] op_e;
  logic [WORD_W-1:0] op_x;
  logic [WORD_W-1:0] op_r;
  logic [WORD_W-1:0] op_r2;
  logic [LEN_W-1:0]  op_len;
  logic [WORD_W-1:0] ladder_result;

  // Shared multiplier link
  logic              mult_start;
  logic              mult_done;
  logic [WORD_W-1:0] mult_a;
  logic [WORD_W-1:0] mult_b;
  logic [WORD_W-1:0] mult_m;
  logic [WORD_W-1:0] mult_res;

  rsa_control u_control (
    .clk(clk), .resetn(resetn), .command(command),
    .addr_m(addr_m), .addr_e(addr_e), .addr_x(addr_x),
    .addr_r(addr_r), .addr_r2(addr_r2), .exp_len(exp_len),
    .rx_data(rx_data), .mem_done(mem_done), .mem_error(mem_error),
    .wb_done(wb_done), .rx_start(rx_start), .rx_address(rx_address),
    .ladder_start(ladder_start), .op_m(op_m), .op_e(op_e), .op_x(op_x),
    .op_r(op_r), .op_r2(op_r2), .op_len(op_len), .status(status)
  );

  mont_ladder u_ladder (
    .clk(clk), .resetn(resetn), .ladder_start(ladder_start),
    .op_m(op_m), .op_e(op_e), .op_x(op_x), .op_r(op_r), .op_r2(op_r2),
    .op_len(op_len), .mult_done(mult_done), .mult_res(mult_res),
    .mult_start(mult_start), .mult_a(mult_a), .mult_b(mult_b),
    .mult_m(mult_m), .ladder_done(ladder_done), .ladder_result(ladder_result)
  );

  mont_mult u_mult (
    .clk(clk), .resetn(resetn), .mult_start(mult_start),
    .mult_a(mult_a), .mult_b(mult_b), .mult_m(mult_m),
    .mult_done(mult_done), .mult_res(mult_res)
  );

  rsa_result u_result (
    .clk(clk), .resetn(resetn), .ladder_done(ladder_done),
    .ladder_result(ladder_result), .addr_out(addr_out), .mem_done(mem_done),
    .tx_start(tx_start), .tx_address(tx_address), .tx_data(tx_data),
    .wb_done(wb_done)
  );

endmodule

// File: src/rsa_result.sv
module rsa_result (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       ladder_done,
  input  logic [rsa_pkg::WORD_W-1:0] ladder_result,
  input  logic [rsa_pkg::WORD_W-1:0] addr_out,
  input  logic                       mem_done,
  output logic                       tx_start,
  output logic [rsa_pkg::WORD_W-1:0] tx_address,
  output logic [rsa_pkg::WORD_W-1:0] tx_data,
  output logic                       wb_done
);

  logic busy;

  // mem_done only counts while our write is outstanding
  assign wb_done = busy && mem_done;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy     <= 1'b0;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      if (ladder_done) begin
        busy     <= 1'b1;
        tx_start <= 1'b1;
      end else if (wb_done) begin
        busy <= 1'b0;
      end
    end
  end

  // Held until the write completes
  always_ff @(posedge clk) begin
    if (ladder_done) begin
      tx_data    <= ladder_result;
      tx_address <= addr_out;
    end
  end

endmodule

// File: src/rsa_control.sv
module rsa_control (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [rsa_pkg::WORD_W-1:0] command,
  input  logic [rsa_pkg::WORD_W-1:0] addr_m,
  input  logic [rsa_pkg::WORD_W-1:0] addr_e,
  input  logic [rsa_pkg::WORD_W-1:0] addr_x,
  input  logic [rsa_pkg::WORD_W-1:0] addr_r,
  input  logic [rsa_pkg::WORD_W-1:0] addr_r2,
  input  logic [rsa_pkg::LEN_W-1:0]  exp_len,
  input  logic [rsa_pkg::WORD_W-1:0] rx_data,
  input  logic                       mem_done,
  input  logic                       mem_error,
  input  logic                       wb_done,
  output logic                       rx_start,
  output logic [rsa_pkg::WORD_W-1:0] rx_address,
  output logic                       ladder_start,
  output logic [rsa_pkg::WORD_W-1:0] op_m,
  output logic [rsa_pkg::WORD_W-1:0] op_e,
  output logic [rsa_pkg::WORD_W-1:0] op_x,
  output logic [rsa_pkg::WORD_W-1:0] op_r,
  output logic [rsa_pkg::WORD_W-1:0] op_r2,
  output logic [rsa_pkg::LEN_W-1:0]  op_len,
  output logic [rsa_pkg::WORD_W-1:0] status
);
  import rsa_pkg::*;

  ctrl_state_t       state;
  logic [2:0]        rd_sel;
  logic [WORD_W-1:0] rd_addr;
  logic              last_read;
  logic              go;

  assign go        = (state == C_IDLE) && (command == CMD_COMPUTE);
  assign last_read = (rd_sel == 3'd4);

  // Operands are fetched in the order m, e, x, r_mod, r2_mod
  always_comb begin
    case (rd_sel)
      3'd0:    rd_addr = addr_m;
      3'd1:    rd_addr = addr_e;
      3'd2:    rd_addr = addr_x;
      3'd3:    rd_addr = addr_r;
      default: rd_addr = addr_r2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= C_IDLE;
      rd_sel   <= 3'd0;
      rx_start <= 1'b0;
    end else begin
      rx_start <= 1'b0;
      case (state)
        C_IDLE: begin
          if (go) begin
            rd_sel <= 3'd0;
            state  <= C_RX;
          end
        end
        C_RX: begin
          rx_start <= 1'b1;
          state    <= C_RX_WAIT;
        end
        C_RX_WAIT: begin
          if (mem_done) begin
            if (last_read) begin
              state <= C_START;
            end else begin
              rd_sel <= rd_sel + 3'd1;
              state  <= C_RX;
            end
          end
        end
        C_START: state <= C_BUSY;
        C_BUSY: begin
          if (wb_done) begin
            state <= C_DONE;
          end
        end
        // Hold here until the CPU drops the command, or the job would rerun
        C_DONE: begin
          if (command == CMD_IDLE) begin
            state <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      op_len <= exp_len;
    end
    if (state == C_RX) begin
      rx_address <= rd_addr;
    end
    if (state == C_RX_WAIT && mem_done) begin
      case (rd_sel)
        3'd0:    op_m  <= rx_data;
        3'd1:    op_e  <= rx_data;
        3'd2:    op_x  <= rx_data;
        3'd3:    op_r  <= rx_data;
        default: op_r2 <= rx_data;
      endcase
    end
  end

  assign ladder_start = (state == C_START);

  always_comb begin
    status               = '0;
    status[STATUS_DONE]  = (state == C_DONE);
    status[STATUS_IDLE]  = (state == C_IDLE);
    status[STATUS_ERROR] = mem_error;
  end

endmodule

// File: src/mont_ladder.sv
module mont_ladder (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       ladder_start,
  input  logic [rsa_pkg::WORD_W-1:0] op_m,
  input  logic [rsa_pkg::WORD_W-1:0] op_e,
  input  logic [rsa_pkg::WORD_W-1:0] op_x,
  input  logic [rsa_pkg::WORD_W-1:0] op_r,
  input  logic [rsa_pkg::WORD_W-1:0] op_r2,
  input  logic [rsa_pkg::LEN_W-1:0]  op_len,
  input  logic                       mult_done,
  input  logic [rsa_pkg::WORD_W-1:0] mult_res,
  output logic                       mult_start,
  output logic [rsa_pkg::WORD_W-1:0] mult_a,
  output logic [rsa_pkg::WORD_W-1:0] mult_b,
  output logic [rsa_pkg::WORD_W-1:0] mult_m,
  output logic                       ladder_done,
  output logic [rsa_pkg::WORD_W-1:0] ladder_result
);
  import rsa_pkg::*;

  ladder_state_t     state;
  logic [LEN_W-1:0]  bits_left;
  logic [WORD_W-1:0] reg_a;
  logic [WORD_W-1:0] reg_xt;
  logic [WORD_W-1:0] e_sh;
  logic              e_bit;

  // Current exponent bit sits at the top of the shifted copy
  assign e_bit  = e_sh[WORD_W-1];
  assign mult_m = op_m;

  assign mult_start = (state == L_ENTRY) || (state == L_STEP1) ||
                      (state == L_STEP2) || (state == L_EXIT);

  // Operands stay put for the whole multiply, the wait states select the same
  always_comb begin
    mult_a = reg_a;
    mult_b = reg_xt;
    case (state)
      L_ENTRY, L_ENTRY_WAIT: begin
        mult_a = op_x;
        mult_b = op_r2;
      end
      L_STEP2, L_STEP2_WAIT: begin
        if (e_bit) begin
          mult_a = reg_xt;
          mult_b = reg_xt;
        end else begin
          mult_a = reg_a;
          mult_b = reg_a;
        end
      end
      // Multiply by one to leave the Montgomery domain
      L_EXIT, L_EXIT_WAIT: begin
        mult_a = reg_a;
        mult_b = WORD_W'(1);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= L_IDLE;
      bits_left   <= '0;
      ladder_done <= 1'b0;
    end else begin
      ladder_done <= 1'b0;
      case (state)
        L_IDLE: begin
          if (ladder_start) begin
            bits_left <= op_len;
            state     <= L_ENTRY;
          end
        end
        L_ENTRY: state <= L_ENTRY_WAIT;
        L_ENTRY_WAIT: begin
          if (mult_done) begin
            state <= (bits_left == '0) ? L_EXIT : L_STEP1;
          end
        end
        L_STEP1: state <= L_STEP1_WAIT;
        L_STEP1_WAIT: begin
          if (mult_done) begin
            state <= L_STEP2;
          end
        end
        L_STEP2: state <= L_STEP2_WAIT;
        L_STEP2_WAIT: begin
          if (mult_done) begin
            bits_left <= bits_left - 1'b1;
            state     <= (bits_left == LEN_W'(1)) ? L_EXIT : L_STEP1;
          end
        end
        L_EXIT: state <= L_EXIT_WAIT;
        L_EXIT_WAIT: begin
          if (mult_done) begin
            ladder_done <= 1'b1;
            state       <= L_IDLE;
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      L_IDLE: begin
        if (ladder_start) begin
          reg_a <= op_r;
          e_sh  <= op_e << (LEN_W'(WORD_W) - op_len);
        end
      end
      L_ENTRY_WAIT: begin
        if (mult_done) begin
          reg_xt <= mult_res;
        end
      end
      // First product is mont(A, Xt) for either bit value
      L_STEP1_WAIT: begin
        if (mult_done) begin
          if (e_bit) begin
            reg_a <= mult_res;
          end else begin
            reg_xt <= mult_res;
          end
        end
      end
      L_STEP2_WAIT: begin
        if (mult_done) begin
          if (e_bit) begin
            reg_xt <= mult_res;
          end else begin
            reg_a <= mult_res;
          end
          e_sh <= e_sh << 1;
        end
      end
      L_EXIT_WAIT: begin
        if (mult_done) begin
          ladder_result <= mult_res;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: src/mont_mult.sv
module mont_mult (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       mult_start,
  input  logic [rsa_pkg::WORD_W-1:0] mult_a,
  input  logic [rsa_pkg::WORD_W-1:0] mult_b,
  input  logic [rsa_pkg::WORD_W-1:0] mult_m,
  output logic                       mult_done,
  output logic [rsa_pkg::WORD_W-1:0] mult_res
);
  import rsa_pkg::*;

  logic              busy;
  logic [LEN_W-1:0]  cnt;
  logic [WORD_W-1:0] a_sh;
  logic [WORD_W:0]   acc;
  logic [WORD_W+1:0] sum_ab;
  logic [WORD_W+1:0] sum_m;
  logic [WORD_W:0]   acc_next;
  logic [WORD_W-1:0] acc_red;

  // Add a_i*b, make even with m, halve
  // acc stays below 2m, so it fits in WORD_W+1 bits
  always_comb begin
    sum_ab   = {1'b0, acc} + (a_sh[0] ? {2'b00, mult_b} : '0);
    sum_m    = sum_ab + (sum_ab[0] ? {2'b00, mult_m} : '0);
    acc_next = sum_m[WORD_W+1:1];
    acc_red  = acc[WORD_W-1:0] - mult_m;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy      <= 1'b0;
      cnt       <= '0;
      mult_done <= 1'b0;
    end else begin
      mult_done <= 1'b0;
      if (mult_start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == LEN_W'(MULT_LATENCY - 2)) begin
          busy      <= 1'b0;
          mult_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mult_start) begin
      a_sh <= mult_a;
      acc  <= '0;
    end else if (busy && cnt < LEN_W'(WORD_W)) begin
      a_sh <= a_sh >> 1;
      acc  <= acc_next;
    end else if (busy && cnt == LEN_W'(WORD_W)) begin
      // Single conditional subtraction brings the result below m
      if (acc >= {1'b0, mult_m}) begin
        mult_res <= acc_red;
      end else begin
        mult_res <= acc[WORD_W-1:0];
      end
    end
  end

endmodule

// File: src/rsa_pkg.sv
package rsa_pkg;

  // Datapath and bus width
  localparam int WORD_W = 32;

  // Exponent length and ladder bit counter, holds 0 to WORD_W
  localparam int LEN_W = 6;

  localparam logic [WORD_W-1:0] CMD_IDLE    = WORD_W'(0);
  localparam logic [WORD_W-1:0] CMD_COMPUTE = WORD_W'(1);

  // Status word bit positions
  localparam int STATUS_DONE  = 0;
  localparam int STATUS_IDLE  = 1;
  localparam int STATUS_ERROR = 2;

  // One load cycle, WORD_W steps, one final subtraction
  localparam int MULT_LATENCY = WORD_W + 2;

  typedef enum logic [3:0] {
    C_IDLE,
    C_RX,
    C_RX_WAIT,
    C_START,
    C_BUSY,
    C_DONE
  } ctrl_state_t;

  typedef enum logic [3:0] {
    L_IDLE,
    L_ENTRY,
    L_ENTRY_WAIT,
    L_STEP1,
    L_STEP1_WAIT,
    L_STEP2,
    L_STEP2_WAIT,
    L_EXIT,
    L_EXIT_WAIT
  } ladder_state_t;

endpackage
